/* hw/GpioBusDecode.sv */
// GPIO bus decode
`timescale 1ns/1ps

module GpioBusDecode #(
	parameter logic [7:0] pBlockMap = 8'h01
)(
	input  logic [31:0]        usiAdrs,
	input  logic [31:0]        usiWd,
	output GpioPkg::csrAccessT access
);

	// --------------------
	// Address fields
	// --------------------
	logic        wrFlag;
	logic        blockHit;
	logic [15:0] ofs;

	assign wrFlag   = usiAdrs[GpioPkg::cWrFlagBit];
	// Block select in bits 23..16
	assign blockHit = (usiAdrs[23:16] == pBlockMap);
	assign ofs      = usiAdrs[15:0];

	// --------------------
	// Strobe generation
	// --------------------
	always_comb
	begin
		access        = '0;
		// Write word passes through untouched
		access.wd.raw = usiWd;
		if (blockHit)
		begin
			if (wrFlag)
			begin
				// One strobe per write cycle
				case (ofs)
					GpioPkg::cOfsEn:        access.wrEn     = 1'b1;
					GpioPkg::cOfsAltMode:   access.wrAlt    = 1'b1;
					GpioPkg::cOfsOut:       access.wrOut    = 1'b1;
					GpioPkg::cOfsOutSetClr: access.wrSetClr = 1'b1;
					default:                access.wrEn     = 1'b0;
				endcase
			end
			else
			begin
				// Set/clear is write-only, no read hit
				case (ofs)
					GpioPkg::cOfsEn:
					begin
						access.rdHit = 1'b1;
						access.rdSel = GpioPkg::cSelEn;
					end
					GpioPkg::cOfsAltMode:
					begin
						access.rdHit = 1'b1;
						access.rdSel = GpioPkg::cSelAltMode;
					end
					GpioPkg::cOfsOut:
					begin
						access.rdHit = 1'b1;
						access.rdSel = GpioPkg::cSelOut;
					end
					GpioPkg::cOfsIn:
					begin
						access.rdHit = 1'b1;
						access.rdSel = GpioPkg::cSelIn;
					end
					default:
						access.rdHit = 1'b0;
				endcase
			end
		end
	end

endmodule

/* hw/GpioCsr.sv */
// GPIO control and status registers
`timescale 1ns/1ps

module GpioCsr #(
	parameter int pGpioWidth = 5
)(
	input  logic                                iSCLK,
	input  logic                                iSRST,
	input  GpioPkg::csrAccessT                  access,
	input  logic [GpioPkg::cGpioMaxWidth-1:0]   gpioSync,
	output GpioPkg::pinCtrlT                    pinCtrl,
	output logic [31:0]                         usiRd
);

	// Low pGpioWidth bits set
	localparam logic [GpioPkg::cGpioMaxWidth-1:0] cWidthMask =
		{GpioPkg::cGpioMaxWidth{1'b1}} >> (GpioPkg::cGpioMaxWidth - pGpioWidth);

	// --------------------
	// Register file
	// --------------------
	logic [GpioPkg::cGpioMaxWidth-1:0] rEn;
	logic [GpioPkg::cGpioMaxWidth-1:0] rAltMode;
	logic [GpioPkg::cGpioMaxWidth-1:0] rOut;

	// Write value clipped to the pin count
	logic [GpioPkg::cGpioMaxWidth-1:0] wdMasked;
	// Output data after set then clear
	logic [GpioPkg::cGpioMaxWidth-1:0] outSetClr;

	assign wdMasked  = access.wd.raw[GpioPkg::cGpioMaxWidth-1:0] & cWidthMask;
	// Clear wins where both masks hit
	assign outSetClr = ((rOut | access.wd.setClr.setMask) & ~access.wd.setClr.clrMask)
		& cWidthMask;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			// Enable comes up on for every pin
			rEn      <= cWidthMask;
			rAltMode <= '0;
			rOut     <= '0;
		end
		else
		begin
			if (access.wrEn)
			begin
				rEn <= wdMasked;
			end
			if (access.wrAlt)
			begin
				rAltMode <= wdMasked;
			end
			// Plain write and set/clear never share a cycle
			if (access.wrOut)
			begin
				rOut <= wdMasked;
			end
			else if (access.wrSetClr)
			begin
				rOut <= outSetClr;
			end
		end
	end

	// Registers straight to the pin stage
	assign pinCtrl.oe      = rEn;
	assign pinCtrl.altMode = rAltMode;
	assign pinCtrl.outData = rOut;

	// --------------------
	// Read mux
	// --------------------
	logic [GpioPkg::cGpioMaxWidth-1:0] rdValue;

	always_comb
	begin
		case (access.rdSel)
			GpioPkg::cSelEn:      rdValue = rEn;
			GpioPkg::cSelAltMode: rdValue = rAltMode;
			GpioPkg::cSelOut:     rdValue = rOut;
			GpioPkg::cSelIn:      rdValue = gpioSync & cWidthMask;
			default:              rdValue = '0;
		endcase
	end

	// Registered one cycle, held on a miss
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			usiRd <= '0;
		end
		else if (access.rdHit)
		begin
			usiRd <= {{(32 - GpioPkg::cGpioMaxWidth){1'b0}}, rdValue};
		end
	end

endmodule

/* hw/GpioPinDrive.sv */
// GPIO pin drive and input sync
`timescale 1ns/1ps

module GpioPinDrive #(
	parameter int pGpioWidth = 5
)(
	input  logic                              iSCLK,
	input  logic                              iSRST,
	input  GpioPkg::pinCtrlT                  pinCtrl,
	input  logic [pGpioWidth-1:0]             gpioIn,
	input  logic [pGpioWidth-1:0]             altOut,
	output logic [pGpioWidth-1:0]             gpioOut,
	output logic [pGpioWidth-1:0]             gpioOe,
	output logic [GpioPkg::cGpioMaxWidth-1:0] gpioSync
);

	// --------------------
	// Output path
	// --------------------
	logic [pGpioWidth-1:0] oeBits;
	logic [pGpioWidth-1:0] altBits;
	logic [pGpioWidth-1:0] outSel;

	assign oeBits  = pinCtrl.oe[pGpioWidth-1:0];
	assign altBits = pinCtrl.altMode[pGpioWidth-1:0];

	// Alternate function per bit, register data otherwise
	assign outSel  = (altBits & altOut) | (~altBits & pinCtrl.outData[pGpioWidth-1:0]);

	// Disabled pins drive low
	assign gpioOut = outSel & oeBits;
	assign gpioOe  = oeBits;

	// --------------------
	// Input synchronizer
	// --------------------
	logic [pGpioWidth-1:0] rSync1;
	logic [pGpioWidth-1:0] rSync2;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rSync1 <= '0;
			rSync2 <= '0;
		end
		else
		begin
			// Two stages against metastability
			rSync1 <= gpioIn;
			rSync2 <= rSync1;
		end
	end

	// Zero above the pin count
	always_comb
	begin
		gpioSync                   = '0;
		gpioSync[pGpioWidth-1:0]   = rSync2;
	end

endmodule

/* hw/GpioPkg.sv */
// GPIO shared definitions
package GpioPkg;

	// --------------------
	// Sizes and bus fields
	// --------------------
	// Widest GPIO count, one half-word per set/clear mask
	localparam int cGpioMaxWidth = 16;

	// Write flag position in the address word
	localparam int cWrFlagBit = 30;

	// Register offsets
	localparam logic [15:0] cOfsEn        = 16'h0000;
	localparam logic [15:0] cOfsAltMode   = 16'h0004;
	localparam logic [15:0] cOfsOut       = 16'h0008;
	localparam logic [15:0] cOfsOutSetClr = 16'h000C;
	localparam logic [15:0] cOfsIn        = 16'h0010;

	// Read select codes
	localparam logic [2:0] cSelEn      = 3'd0;
	localparam logic [2:0] cSelAltMode = 3'd1;
	localparam logic [2:0] cSelOut     = 3'd2;
	localparam logic [2:0] cSelIn      = 3'd4;

	// --------------------
	// Types
	// --------------------
	// Set/clear view of the write word
	typedef struct packed {
		logic [15:0] setMask;
		logic [15:0] clrMask;
	} gpioSetClrT;

	// One write word, plain value or mask pair
	typedef union packed {
		logic [31:0] raw;
		gpioSetClrT  setClr;
	} gpioWdT;

	// Decode to CSR
	typedef struct packed {
		logic       wrEn;
		logic       wrAlt;
		logic       wrOut;
		logic       wrSetClr;
		logic       rdHit;
		logic [2:0] rdSel;
		gpioWdT     wd;
	} csrAccessT;

	// CSR to pin drive, low pGpioWidth bits meaningful
	typedef struct packed {
		logic [cGpioMaxWidth-1:0] oe;
		logic [cGpioMaxWidth-1:0] altMode;
		logic [cGpioMaxWidth-1:0] outData;
	} pinCtrlT;

endpackage

/* hw/GpioTop.sv */
// GPIO subsystem top
`timescale 1ns/1ps

module GpioTop #(
	parameter logic [7:0] pBlockMap  = 8'h01,
	parameter int         pGpioWidth = 5
)(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	// Bus side
	input  logic [31:0]           usiAdrs,
	input  logic [31:0]           usiWd,
	output logic [31:0]           usiRd,
	// Pin side
	input  logic [pGpioWidth-1:0] gpioIn,
	input  logic [pGpioWidth-1:0] altOut,
	output logic [pGpioWidth-1:0] gpioOut,
	output logic [pGpioWidth-1:0] gpioOe,
	output logic [pGpioWidth-1:0] altMode
);

	// --------------------
	// Stage links
	// --------------------
	GpioPkg::csrAccessT                access;
	GpioPkg::pinCtrlT                  pinCtrl;
	logic [GpioPkg::cGpioMaxWidth-1:0] gpioSync;

	// Alternate mode out to the external function mux
	assign altMode = pinCtrl.altMode[pGpioWidth-1:0];

	// Decode stage
	GpioBusDecode #(
		.pBlockMap (pBlockMap)
	) uDecode (
		.usiAdrs (usiAdrs),
		.usiWd   (usiWd),
		.access  (access)
	);

	// Execute stage
	GpioCsr #(
		.pGpioWidth (pGpioWidth)
	) uCsr (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.access   (access),
		.gpioSync (gpioSync),
		.pinCtrl  (pinCtrl),
		.usiRd    (usiRd)
	);

	// Result stage
	GpioPinDrive #(
		.pGpioWidth (pGpioWidth)
	) uPinDrive (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.pinCtrl  (pinCtrl),
		.gpioIn   (gpioIn),
		.altOut   (altOut),
		.gpioOut  (gpioOut),
		.gpioOe   (gpioOe),
		.gpioSync (gpioSync)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module GpioTb -o GpioTbSim

./obj_dir/GpioTbSim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run.sh: testbench reported success"
else
	echo "run.sh: testbench reported failure"
	exit 1
fi

/* sim.f */
hw/GpioPkg.sv
hw/GpioBusDecode.sv
hw/GpioCsr.sv
hw/GpioPinDrive.sv
hw/GpioTop.sv
sim/GpioTb.sv

/* sim/GpioTb.sv */
// GPIO testbench
`timescale 1ns/1ps

module GpioTb;

	localparam logic [7:0]  cBlockMap   = 8'h01;
	localparam int          cGpioWidth  = 5;
	localparam logic [15:0] cWidthMask  = 16'((32'd1 << cGpioWidth) - 1);
	// Rough cycle count of all tests, doubled in the watchdog
	localparam int          cTestCycles = 500;
	localparam int          cWatchdogNs = cTestCycles * 8 * 2;

	logic                  iSCLK = 1'b0;
	logic                  iSRST;
	logic [31:0]           usiAdrs;
	logic [31:0]           usiWd;
	logic [31:0]           usiRd;
	logic [cGpioWidth-1:0] gpioIn;
	logic [cGpioWidth-1:0] altOut;
	logic [cGpioWidth-1:0] gpioOut;
	logic [cGpioWidth-1:0] gpioOe;
	logic [cGpioWidth-1:0] altMode;

	// Reference registers, updated after the latching edge
	logic [15:0]           mEn;
	logic [15:0]           mAlt;
	logic [15:0]           mOut;
	logic [cGpioWidth-1:0] expOe;
	logic [cGpioWidth-1:0] expAlt;
	logic [cGpioWidth-1:0] expOut;

	int errCount   = 0;
	int checkCount = 0;
	int testCount  = 0;

	always #4 iSCLK = ~iSCLK;

	GpioTop #(
		.pBlockMap  (cBlockMap),
		.pGpioWidth (cGpioWidth)
	) DUT (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.usiAdrs (usiAdrs),
		.usiWd   (usiWd),
		.usiRd   (usiRd),
		.gpioIn  (gpioIn),
		.altOut  (altOut),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe),
		.altMode (altMode)
	);

	// --------------------
	// Expected pin state
	// --------------------
	assign expOe  = mEn[cGpioWidth-1:0];
	assign expAlt = mAlt[cGpioWidth-1:0];

	// Disabled pin low, else alternate or register data
	always_comb
	begin
		for (int b = 0; b < cGpioWidth; b++)
		begin
			if (!mEn[b])
				expOut[b] = 1'b0;
			else if (mAlt[b])
				expOut[b] = altOut[b];
			else
				expOut[b] = mOut[b];
		end
	end

	// Pins checked on every edge out of reset
	assert property (@(posedge iSCLK) disable iff (iSRST) gpioOe == expOe)
	else
	begin
		$display("error gpioOe got %h expected %h", $sampled(gpioOe), $sampled(expOe));
		errCount++;
	end
	assert property (@(posedge iSCLK) disable iff (iSRST) gpioOut == expOut)
	else
	begin
		$display("error gpioOut got %h expected %h", $sampled(gpioOut), $sampled(expOut));
		errCount++;
	end
	assert property (@(posedge iSCLK) disable iff (iSRST) altMode == expAlt)
	else
	begin
		$display("error altMode got %h expected %h", $sampled(altMode), $sampled(expAlt));
		errCount++;
	end

	// --------------------
	// Bus tasks
	// --------------------
	// One cycle on the bus, returns just after the latching edge with the bus idle
	task automatic busAccess(input logic wr, input logic [7:0] map, input logic [15:0] ofs,
		input logic [31:0] data);
		usiAdrs = {1'b0, wr, 6'b0, map, ofs};
		usiWd   = data;
		@(posedge iSCLK);
		#1;
		usiAdrs = {8'h00, ~cBlockMap, 16'h0000};
		usiWd   = '0;
	endtask

	task automatic readCheck(input logic [15:0] ofs, input logic [31:0] exp);
		busAccess(1'b0, cBlockMap, ofs, 32'h0);
		checkCount++;
		assert (usiRd === exp)
		else
		begin
			$display("error usiRd at offset %h got %h expected %h", ofs, usiRd, exp);
			errCount++;
		end
	endtask

	task automatic pinCheck();
		checkCount++;
		assert (gpioOut === expOut && gpioOe === expOe)
		else
		begin
			$display("error gpioOut got %h expected %h, gpioOe got %h expected %h",
				gpioOut, expOut, gpioOe, expOe);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		testCount++;
		$display("test %0d %-10s done, %0d errors", testCount, name, errCount - errStart);
	endtask

	// Random word and its clipped register image
	function automatic logic [15:0] clip(input logic [31:0] d);
		return d[15:0] & cWidthMask;
	endfunction

	// Per pin, clear beats set, untouched pins keep their value
	function automatic logic [15:0] applySetClr(input logic [15:0] old, input logic [31:0] d);
		logic [15:0] r;
		for (int b = 0; b < 16; b++)
		begin
			if (d[b])
				r[b] = 1'b0;
			else if (d[16+b])
				r[b] = 1'b1;
			else
				r[b] = old[b];
		end
		return r & cWidthMask;
	endfunction

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin
		int          errStart;
		logic [31:0] d;
		logic [31:0] lastRd;
		void'($urandom(9422));
		iSRST   = 1'b1;
		usiAdrs = '0;
		usiWd   = '0;
		gpioIn  = '0;
		altOut  = '0;
		mEn     = cWidthMask;
		mAlt    = '0;
		mOut    = '0;
		repeat (8) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;

		// Reset values
		errStart = errCount;
		pinCheck();
		readCheck(GpioPkg::cOfsEn, {16'h0, cWidthMask});
		readCheck(GpioPkg::cOfsAltMode, 32'h0);
		readCheck(GpioPkg::cOfsOut, 32'h0);
		reportTest("reset", errStart);

		// Plain write and read back, upper bits clipped
		errStart = errCount;
		for (int i = 0; i < 20; i++)
		begin
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsEn, d);
			mEn = clip(d);
			readCheck(GpioPkg::cOfsEn, {16'h0, mEn});
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsAltMode, d);
			mAlt = clip(d);
			readCheck(GpioPkg::cOfsAltMode, {16'h0, mAlt});
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsOut, d);
			mOut = clip(d);
			readCheck(GpioPkg::cOfsOut, {16'h0, mOut});
		end
		reportTest("readback", errStart);

		// Set then clear, all pins enabled and plain
		errStart = errCount;
		busAccess(1'b1, cBlockMap, GpioPkg::cOfsEn, 32'hFFFF_FFFF);
		mEn = cWidthMask;
		busAccess(1'b1, cBlockMap, GpioPkg::cOfsAltMode, 32'h0);
		mAlt = '0;
		for (int i = 0; i < 21; i++)
		begin
			// Last pass forces full overlap of both masks
			d = (i == 20) ? 32'hFFFF_FFFF : $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsOutSetClr, d);
			mOut = applySetClr(mOut, d);
			#1;
			pinCheck();
			readCheck(GpioPkg::cOfsOut, {16'h0, mOut});
		end
		reportTest("setclr", errStart);

		// Mixed enable and alternate mode
		errStart = errCount;
		for (int i = 0; i < 20; i++)
		begin
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsEn, d);
			mEn = clip(d);
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsAltMode, d);
			mAlt = clip(d);
			d = $urandom();
			busAccess(1'b1, cBlockMap, GpioPkg::cOfsOut, d);
			mOut = clip(d);
			d = $urandom();
			altOut = d[cGpioWidth-1:0];
			#1;
			pinCheck();
			@(posedge iSCLK);
			#1;
		end
		reportTest("pinselect", errStart);

		// Input synchronizer, read three cycles after the change
		errStart = errCount;
		for (int i = 0; i < 10; i++)
		begin
			d = $urandom();
			gpioIn = d[cGpioWidth-1:0];
			repeat (3) @(posedge iSCLK);
			#1;
			readCheck(GpioPkg::cOfsIn, {27'h0, gpioIn});
		end
		reportTest("insync", errStart);

		// Wrong block map, unknown offsets, write-only read
		errStart = errCount;
		for (int i = 0; i < 8; i++)
		begin
			d = $urandom();
			busAccess(1'b1, cBlockMap + 8'd1, GpioPkg::cOfsEn, d);
			busAccess(1'b1, cBlockMap ^ 8'h80, GpioPkg::cOfsOutSetClr, d);
			busAccess(1'b1, cBlockMap, 16'h0014, d);
			busAccess(1'b1, cBlockMap, 16'h0002, d);
			readCheck(GpioPkg::cOfsOut, {16'h0, mOut});
			lastRd = {16'h0, mOut};
			readCheck(16'h0014, lastRd);
			readCheck(GpioPkg::cOfsOutSetClr, lastRd);
			readCheck(GpioPkg::cOfsEn, {16'h0, mEn});
		end
		reportTest("filter", errStart);

		$display("tests %0d, direct checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(cWatchdogNs);
		$display("Watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
